/* rtl/lsu_consts.svh */
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// number of load/store queue entries.
`define LSU_QUEUE_DEPTH 8

// number of 32-bit data RAM words, indexed by address bits 7:2.
`define LSU_RAM_WORDS 64

// length of the memory access window in cycles.
`define LSU_MEM_WAIT 2

// reorder buffer tag width.
`define LSU_ROB_ID_W 5

`endif

/* rtl/lsu_pkg.sv */
`include "lsu_consts.svh"

package lsu_pkg;

    typedef logic [31:0]               word_t;
    typedef logic [3:0]                mask_t;
    typedef logic [`LSU_ROB_ID_W-1:0]  rob_id_t;

    // memory opcodes, loads first.
    typedef enum logic [2:0] {
        LB, LH, LW, LBU, LHU, SB, SH, SW
    } mem_op_t;

    typedef enum logic [1:0] {
        IDLE, ACCESS, RESPOND
    } mem_state_t;

    // ------------------------------
    // issue request from the reservation station.
    typedef struct packed {
        rob_id_t  rob_id;
        mem_op_t  op;
        word_t    rs1_value;
        word_t    rs2_value;
        word_t    imm;
    } agu_req_t;

    // queue entry, data already on its byte lanes.
    typedef struct packed {
        rob_id_t  rob_id;
        mem_op_t  op;
        word_t    addr;
        word_t    wdata;
        mask_t    mask;
    } lsq_entry_t;

    // completion back to the ROB.
    typedef struct packed {
        rob_id_t  rob_id;
        word_t    data;
    } ls_result_t;

endpackage

/* rtl/lsu_agu.sv */
`timescale 1ns/1ps

module lsu_agu (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  lsu_pkg::agu_req_t    in_req,
    output logic                 out_valid,
    output lsu_pkg::lsq_entry_t  out_entry
);

    lsu_pkg::agu_req_t  req_q;
    lsu_pkg::word_t     addr;
    lsu_pkg::word_t     wdata;
    lsu_pkg::mask_t     mask;

    // the stage never stalls.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            req_q <= in_req;
        end
    end

    assign addr = req_q.rs1_value + req_q.imm;

    // ------------------------------
    // store data lane placement.
    always_comb begin
        wdata = '0;
        case (req_q.op)
            lsu_pkg::SB: wdata[8*addr[1:0] +: 8] = req_q.rs2_value[7:0];
            lsu_pkg::SH: wdata[16*addr[1] +: 16] = req_q.rs2_value[15:0];
            lsu_pkg::SW: wdata = req_q.rs2_value;
            default:     wdata = '0;
        endcase
    end

    // byte mask from access size and low address bits.
    always_comb begin
        case (req_q.op)
            lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: mask = 4'b0001 << addr[1:0];
            lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: mask = 4'b0011 << addr[1:0];
            default:                                mask = 4'b1111;
        endcase
    end

    assign out_entry = '{
        rob_id: req_q.rob_id,
        op:     req_q.op,
        addr:   addr,
        wdata:  wdata,
        mask:   mask
    };

endmodule

/* rtl/lsu_queue.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_queue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  lsu_pkg::lsq_entry_t  push_entry,
    input  logic                 pop,
    output lsu_pkg::lsq_entry_t  head,
    output logic                 head_valid,
    output logic                 issue_ready
);

    localparam int DEPTH = `LSU_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    lsu_pkg::lsq_entry_t  entries [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head       = entries[rd_ptr];
    assign head_valid = (count != '0);

    // one slot is held back for the request still inside the AGU.
    assign issue_ready = (count < CNT_W'(DEPTH - 1));

endmodule

/* rtl/lsu_wait_timer.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_wait_timer (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    output logic  expired
);

    localparam int CNT_W = $clog2(`LSU_MEM_WAIT + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_W'(`LSU_MEM_WAIT);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // last cycle of the window.
    assign expired = (count == CNT_W'(1));

endmodule

/* rtl/lsu_data_ram.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_data_ram (
    input  logic                                clk,
    input  logic [$clog2(`LSU_RAM_WORDS)-1:0]   index,
    input  logic                                we,
    input  lsu_pkg::mask_t                      wmask,
    input  lsu_pkg::word_t                      wdata,
    output lsu_pkg::word_t                      rdata
);

    lsu_pkg::word_t mem [`LSU_RAM_WORDS];

    // byte-lane writes under the mask.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (wmask[i]) begin
                    mem[index][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata <= mem[index];
    end

endmodule

/* rtl/lsu_load_align.sv */
`timescale 1ns/1ps

module lsu_load_align (
    input  lsu_pkg::mem_op_t  op,
    input  logic [1:0]        byte_sel,
    input  lsu_pkg::word_t    word,
    output lsu_pkg::word_t    data
);

    lsu_pkg::word_t shifted;

    // addressed byte or halfword moved down to bit 0.
    assign shifted = word >> {byte_sel, 3'b000};

    always_comb begin
        case (op)
            lsu_pkg::LB:  data = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::LH:  data = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::LBU: data = {24'b0, shifted[7:0]};
            lsu_pkg::LHU: data = {16'b0, shifted[15:0]};
            default:      data = word;
        endcase
    end

endmodule

/* rtl/lsu_mem_fsm.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_mem_fsm (
    input  logic                               clk,
    input  logic                               rst,
    input  lsu_pkg::lsq_entry_t                head,
    input  logic                               head_valid,
    output logic                               pop,
    output logic                               start,
    input  logic                               expired,
    output logic [$clog2(`LSU_RAM_WORDS)-1:0]  ram_index,
    output logic                               ram_we,
    output lsu_pkg::mask_t                     ram_wmask,
    output lsu_pkg::word_t                     ram_wdata,
    input  lsu_pkg::word_t                     ram_rdata,
    output logic                               result_valid,
    output lsu_pkg::ls_result_t                result
);

    localparam int IDX_W = $clog2(`LSU_RAM_WORDS);

    lsu_pkg::mem_state_t  state;
    lsu_pkg::mem_state_t  state_nxt;
    lsu_pkg::lsq_entry_t  cur;
    lsu_pkg::word_t       load_data;
    logic                 is_store;

    assign pop      = (state == lsu_pkg::IDLE) && head_valid;
    assign start    = pop;
    assign is_store = cur.op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};

    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            lsu_pkg::IDLE:    if (head_valid) state_nxt = lsu_pkg::ACCESS;
            lsu_pkg::ACCESS:  if (expired) state_nxt = lsu_pkg::RESPOND;
            default:          state_nxt = lsu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= head;
        end
    end

    // ------------------------------
    assign ram_index = cur.addr[IDX_W+1:2];
    assign ram_we    = (state == lsu_pkg::RESPOND) && is_store;
    assign ram_wmask = cur.mask;
    assign ram_wdata = cur.wdata;

    lsu_load_align u_align (
        .op       (cur.op),
        .byte_sel (cur.addr[1:0]),
        .word     (ram_rdata),
        .data     (load_data)
    );

    // data only means something for loads.
    assign result_valid = (state == lsu_pkg::RESPOND);
    assign result       = '{rob_id: cur.rob_id, data: load_data};

endmodule

/* rtl/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  lsu_pkg::agu_req_t    issue_req,
    output logic                 issue_ready,
    output logic                 result_valid,
    output lsu_pkg::ls_result_t  result
);

    logic                                agu_valid;
    lsu_pkg::lsq_entry_t                 agu_out;
    lsu_pkg::lsq_entry_t                 head;
    logic                                head_valid;
    logic                                pop;
    logic                                start;
    logic                                expired;
    logic [$clog2(`LSU_RAM_WORDS)-1:0]   ram_index;
    logic                                ram_we;
    lsu_pkg::mask_t                      ram_wmask;
    lsu_pkg::word_t                      ram_wdata;
    lsu_pkg::word_t                      ram_rdata;

    lsu_agu u_agu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (issue_valid && issue_ready),
        .in_req    (issue_req),
        .out_valid (agu_valid),
        .out_entry (agu_out)
    );

    lsu_queue u_queue (
        .clk         (clk),
        .rst         (rst),
        .push        (agu_valid),
        .push_entry  (agu_out),
        .pop         (pop),
        .head        (head),
        .head_valid  (head_valid),
        .issue_ready (issue_ready)
    );

    lsu_mem_fsm u_fsm (
        .clk          (clk),
        .rst          (rst),
        .head         (head),
        .head_valid   (head_valid),
        .pop          (pop),
        .start        (start),
        .expired      (expired),
        .ram_index    (ram_index),
        .ram_we       (ram_we),
        .ram_wmask    (ram_wmask),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata),
        .result_valid (result_valid),
        .result       (result)
    );

    lsu_wait_timer u_timer (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .expired (expired)
    );

    lsu_data_ram u_ram (
        .clk   (clk),
        .index (ram_index),
        .we    (ram_we),
        .wmask (ram_wmask),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

endmodule

/* sim/lsu_checker.sv */
`timescale 1ns/1ps

module lsu_checker (
    input  logic  clk,
    input  logic  rst,
    input  logic  issue_valid,
    input  logic  issue_ready,
    input  logic  result_valid
);

    // completion is a single-cycle strobe.
    result_strobe_single: assert property (
        @(posedge clk) disable iff (rst) result_valid |=> !result_valid
    ) else $error("result_valid high on two consecutive cycles");

    // the issue side never offers a request while the queue holds it off.
    issue_held_off: assert property (
        @(posedge clk) disable iff (rst) issue_valid |-> issue_ready
    ) else $error("issue_valid high while issue_ready is low");

    result_quiet_after_reset: assert property (
        @(posedge clk) rst |=> !result_valid
    ) else $error("result_valid high in the cycle after reset");

endmodule

bind lsu_top lsu_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .result_valid (result_valid)
);

/* sim/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_tb;

    typedef struct packed {
        lsu_pkg::mem_op_t  op;
        lsu_pkg::word_t    rs1;
        lsu_pkg::word_t    rs2;
        lsu_pkg::word_t    imm;
        lsu_pkg::rob_id_t  rob_id;
        logic              rnd;
    } row_t;

    typedef struct packed {
        logic              is_load;
        lsu_pkg::rob_id_t  rob_id;
        lsu_pkg::word_t    data;
    } expect_t;

    localparam int NROWS = 37;
    localparam int MEM_BYTES = `LSU_RAM_WORDS * 4;
    localparam int WATCHDOG_NS = NROWS * (`LSU_MEM_WAIT + 2) * 4 + 200;

    // op, rs1, rs2, imm, rob_id, random rs2.
    localparam row_t STIM_TABLE [NROWS] = '{
        '{lsu_pkg::SW,  32'h10, 32'h1234_5678, 32'h0, 5'd1, 1'b0},
        '{lsu_pkg::LW,  32'h08, 32'h0, 32'h8, 5'd2, 1'b0},
        // byte lanes, two words so some bytes stay untouched.
        '{lsu_pkg::SW,  32'h20, 32'h1122_3344, 32'h0, 5'd3, 1'b0},
        '{lsu_pkg::SW,  32'h20, 32'h5566_7788, 32'h4, 5'd4, 1'b0},
        '{lsu_pkg::SB,  32'h20, 32'hFFFF_FF80, 32'h0, 5'd5, 1'b0},
        '{lsu_pkg::SB,  32'h24, 32'h0000_117F, 32'h1, 5'd6, 1'b0},
        '{lsu_pkg::SB,  32'h20, 32'h0000_00C3, 32'h2, 5'd7, 1'b0},
        '{lsu_pkg::SB,  32'h24, 32'hABCD_EF05, 32'h3, 5'd8, 1'b0},
        '{lsu_pkg::LB,  32'h20, 32'h0, 32'h0, 5'd9, 1'b0},
        '{lsu_pkg::LBU, 32'h20, 32'h0, 32'h0, 5'd10, 1'b0},
        '{lsu_pkg::LB,  32'h24, 32'h0, 32'h1, 5'd11, 1'b0},
        '{lsu_pkg::LBU, 32'h24, 32'h0, 32'h1, 5'd12, 1'b0},
        '{lsu_pkg::LB,  32'h20, 32'h0, 32'h2, 5'd13, 1'b0},
        '{lsu_pkg::LBU, 32'h20, 32'h0, 32'h2, 5'd14, 1'b0},
        '{lsu_pkg::LB,  32'h24, 32'h0, 32'h3, 5'd15, 1'b0},
        '{lsu_pkg::LBU, 32'h24, 32'h0, 32'h3, 5'd16, 1'b0},
        '{lsu_pkg::LW,  32'h20, 32'h0, 32'h0, 5'd17, 1'b0},
        '{lsu_pkg::LW,  32'h20, 32'h0, 32'h4, 5'd18, 1'b0},
        // halfwords.
        '{lsu_pkg::SH,  32'h40, 32'h0000_8001, 32'h0, 5'd19, 1'b0},
        '{lsu_pkg::SH,  32'h40, 32'h5A5A_7FFE, 32'h2, 5'd20, 1'b0},
        '{lsu_pkg::LH,  32'h40, 32'h0, 32'h0, 5'd21, 1'b0},
        '{lsu_pkg::LHU, 32'h40, 32'h0, 32'h0, 5'd22, 1'b0},
        '{lsu_pkg::LH,  32'h40, 32'h0, 32'h2, 5'd23, 1'b0},
        '{lsu_pkg::LHU, 32'h40, 32'h0, 32'h2, 5'd24, 1'b0},
        '{lsu_pkg::LW,  32'h40, 32'h0, 32'h0, 5'd25, 1'b0},
        // random store data burst.
        '{lsu_pkg::SW,  32'h60, 32'h0, 32'hFFFF_FFF0, 5'd26, 1'b1},
        '{lsu_pkg::SB,  32'h50, 32'h0, 32'h1, 5'd27, 1'b1},
        '{lsu_pkg::LW,  32'h50, 32'h0, 32'h0, 5'd28, 1'b0},
        '{lsu_pkg::SH,  32'h50, 32'h0, 32'h2, 5'd29, 1'b1},
        '{lsu_pkg::LHU, 32'h50, 32'h0, 32'h2, 5'd30, 1'b0},
        '{lsu_pkg::LB,  32'h4C, 32'h0, 32'h5, 5'd31, 1'b0},
        '{lsu_pkg::SW,  32'h30, 32'h0, 32'hFFFF_FFF0, 5'd0, 1'b1},
        '{lsu_pkg::LBU, 32'h20, 32'h0, 32'h3, 5'd1, 1'b0},
        '{lsu_pkg::SB,  32'h40, 32'h0, 32'h3, 5'd2, 1'b1},
        '{lsu_pkg::LH,  32'h40, 32'h0, 32'h2, 5'd3, 1'b0},
        '{lsu_pkg::LW,  32'h44, 32'h0, 32'hFFFF_FFFC, 5'd4, 1'b0},
        '{lsu_pkg::LW,  32'h24, 32'h0, 32'h0, 5'd5, 1'b0}
    };

    logic                 clk;
    logic                 rst;
    logic                 issue_valid;
    lsu_pkg::agu_req_t    issue_req;
    logic                 issue_ready;
    logic                 result_valid;
    lsu_pkg::ls_result_t  result;

    logic [7:0]      ref_mem [MEM_BYTES];
    expect_t         exp_q [$];
    expect_t         exp_cur;
    row_t            row;
    lsu_pkg::word_t  addr;
    int              done_count = 0;
    logic            in_burst = 1'b0;
    logic            saw_ready_low = 1'b0;
    logic            saw_ready_back = 1'b0;

    lsu_top UUT (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_req    (issue_req),
        .issue_ready  (issue_ready),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------
    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_rob_id(lsu_pkg::rob_id_t got, lsu_pkg::rob_id_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: rob_id is %0d, expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(lsu_pkg::word_t got, lsu_pkg::word_t exp, lsu_pkg::rob_id_t id);
        if (got !== exp) begin
            $display("ERROR at %0t ns: load rob %0d returned %h, expected %h",
                     $time, id, got, exp);
            abort_run();
        end
    endtask

    task automatic check_level(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // reference memory, little endian bytes.
    task automatic model_store(lsu_pkg::mem_op_t op, lsu_pkg::word_t a, lsu_pkg::word_t d);
        int base;
        int n;
        base = a % MEM_BYTES;
        n = (op == lsu_pkg::SB) ? 1 : ((op == lsu_pkg::SH) ? 2 : 4);
        for (int i = 0; i < n; i++) begin
            ref_mem[base + i] = d[8*i +: 8];
        end
    endtask

    function automatic lsu_pkg::word_t model_load(lsu_pkg::mem_op_t op, lsu_pkg::word_t a);
        int b;
        b = a % MEM_BYTES;
        case (op)
            lsu_pkg::LB:  return {{24{ref_mem[b][7]}}, ref_mem[b]};
            lsu_pkg::LBU: return {24'b0, ref_mem[b]};
            lsu_pkg::LH:  return {{16{ref_mem[b+1][7]}}, ref_mem[b+1], ref_mem[b]};
            lsu_pkg::LHU: return {16'b0, ref_mem[b+1], ref_mem[b]};
            default:      return {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
        endcase
    endfunction

    // ------------------------------
    // results are sampled mid-cycle, away from the active edge.
    always @(negedge clk) begin
        if (!rst) begin
            if (in_burst) begin
                if (!issue_ready) begin
                    saw_ready_low <= 1'b1;
                end else if (saw_ready_low) begin
                    saw_ready_back <= 1'b1;
                end
            end
            if (result_valid) begin
                if (exp_q.size() == 0) begin
                    $display("a result arrived with no outstanding issue");
                    abort_run();
                end
                exp_cur = exp_q.pop_front();
                check_rob_id(result.rob_id, exp_cur.rob_id);
                if (exp_cur.is_load) begin
                    check_word(result.data, exp_cur.data, exp_cur.rob_id);
                end
                done_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, results stopped arriving after %0d of %0d",
                 done_count, NROWS);
        abort_run();
    end

    initial begin
        void'($urandom(53));
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_req = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_level(result_valid, 1'b0, "result_valid after reset");
        check_level(issue_ready, 1'b1, "issue_ready after reset");

        for (int i = 0; i < NROWS; i++) begin
            while (!issue_ready) begin
                issue_valid = 1'b0;
                @(negedge clk);
            end
            row = STIM_TABLE[i];
            if (row.rnd) begin
                in_burst = 1'b1;
                row.rs2 = $urandom;
            end
            addr = row.rs1 + row.imm;
            issue_req = '{rob_id: row.rob_id, op: row.op, rs1_value: row.rs1,
                          rs2_value: row.rs2, imm: row.imm};
            issue_valid = 1'b1;
            if (row.op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW}) begin
                model_store(row.op, addr, row.rs2);
                exp_q.push_back(expect_t'{1'b0, row.rob_id, 32'h0});
            end else begin
                exp_q.push_back(expect_t'{1'b1, row.rob_id, model_load(row.op, addr)});
            end
            @(negedge clk);
        end
        issue_valid = 1'b0;

        wait (done_count == NROWS);
        if (saw_ready_low && saw_ready_back) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("issue_ready never fell and recovered during the random burst");
            abort_run();
        end
    end

endmodule

/* project.f */
+incdir+rtl
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_queue.sv
rtl/lsu_wait_timer.sv
rtl/lsu_data_ram.sv
rtl/lsu_load_align.sv
rtl/lsu_mem_fsm.sv
rtl/lsu_top.sv
sim/lsu_checker.sv
sim/lsu_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = lsu_tb
FILELIST = project.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
